// File: Bender.yml
package:
  name: cpu_control

sources:
  - include_dirs:
      - .
    files:
      - cpuControlPkg.sv
      - instrDecoder.sv
      - interruptArbiter.sv
      - startupSequencer.sv
      - controlSequencer.sv
      - cpuControl.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbCpuControl.sv

// File: controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings_settings.svh"

module controlSequencer (
    input  wire logic                     clk,
    input  wire logic                     arstN,
    input  wire cpuControlPkg::decoded_t  dec,
    input  wire logic                     interruptEnable,
    input  wire logic                     irqPending,
    input  wire logic                     resetReq,
    input  wire logic                     startDone,
    output cpuControlPkg::ctrlWord_t      ctrl,
    output logic                          take,
    output logic                          inStart,
    output logic                          resetOut
);

    localparam logic [3:0] SpReg = 4'(`CPU_SP_LOW_REG);

    cpuControlPkg::state_t state, nextState;

    // stack write through the low sp register, sp counts down
    function automatic cpuControlPkg::ctrlWord_t pushWord(input cpuControlPkg::dataSel_t sel);
        cpuControlPkg::ctrlWord_t w;
        w = '0;
        w.regFileOutBSelect = SpReg;
        w.spDecrement       = 1'b1;
        w.dMemDataSelect    = sel;
        w.dMemWriteEn       = 1'b1;
        return w;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cpuControlPkg::S_START;
        end else begin
            state <= nextState;
        end
    end

    assign inStart  = (state == cpuControlPkg::S_START) && !resetReq;  // count once sync clears
    assign resetOut = (state == cpuControlPkg::S_RESET);

    // ********************
    // next state and control word
    always_comb begin
        ctrl      = '0;         // idle word, sequential fetch, alu flags
        take      = 1'b0;
        nextState = cpuControlPkg::S_PART1;
        case (state)
            cpuControlPkg::S_PART1, cpuControlPkg::S_PART2, cpuControlPkg::S_PART3: begin
                if (resetReq) begin
                    nextState = cpuControlPkg::S_RESET;  // enables stay low
                end else if (state == cpuControlPkg::S_PART1 && interruptEnable && irqPending
                             && !dec.uninterruptible) begin
                    ctrl                 = pushWord(cpuControlPkg::D_ADDR_LSB);
                    ctrl.statusSrcSelect = cpuControlPkg::STS_DISABLE_IRQ;
                    ctrl.flagEnable      = 1'b1;
                    ctrl.iMemAddrSelect  = cpuControlPkg::F_IRQ_VECTOR;
                    nextState            = cpuControlPkg::S_INTERRUPT;
                end else begin
                    ctrl.iMemReadEnable = 1'b1;  // most forms advance in one cycle
                    ctrl.pcWriteEn      = 1'b1;
                    case (dec.instrClass)
                        cpuControlPkg::C_ALU_IMM: begin
                            ctrl.regFileWriteEnable = 1'b1;
                            ctrl.aluSrcBImm         = 1'b1;  // 8-bit immediate
                            ctrl.aluMode            = dec.aluMode;
                            ctrl.flagEnable         = dec.flagUpdate;
                        end
                        cpuControlPkg::C_ALU_REG: begin
                            ctrl.regFileWriteEnable = 1'b1;
                            ctrl.regFileOutBSelect  = dec.regBSelect;
                            ctrl.aluMode            = dec.aluMode;
                            ctrl.flagEnable         = dec.flagUpdate;
                        end
                        cpuControlPkg::C_BRANCH: begin
                            if (dec.condMet) begin
                                ctrl.iMemAddrSelect = dec.branchAbs ? cpuControlPkg::F_BRANCH_ABS
                                                                    : cpuControlPkg::F_BRANCH_REL;
                            end
                        end
                        cpuControlPkg::C_JUMP: begin
                            if (dec.condMet) begin
                                nextState = cpuControlPkg::S_JUMP;  // fetch target word
                            end else begin
                                ctrl.iMemAddrSelect = cpuControlPkg::F_PC_PLUS_ONE;
                            end
                        end
                        cpuControlPkg::C_CALL: begin
                            if (dec.condMet) begin
                                ctrl                = pushWord(cpuControlPkg::D_PC1_LSB);
                                ctrl.iMemReadEnable = 1'b1;  // pc held for msb push
                                nextState           = cpuControlPkg::S_CALL;
                            end else begin
                                ctrl.iMemAddrSelect = cpuControlPkg::F_PC_PLUS_ONE;
                            end
                        end
                        cpuControlPkg::C_RET: begin
                            ctrl.regFileOutBSelect = SpReg;
                            if (state == cpuControlPkg::S_PART3) begin
                                ctrl.iMemAddrSelect = cpuControlPkg::F_RET_ADDR;
                            end else if (state == cpuControlPkg::S_PART2 || dec.condMet) begin
                                ctrl.dMemReadEn     = 1'b1;  // pop one byte
                                ctrl.iMemReadEnable = 1'b0;
                                ctrl.pcWriteEn      = 1'b0;
                                nextState = (state == cpuControlPkg::S_PART1)
                                    ? cpuControlPkg::S_PART2 : cpuControlPkg::S_PART3;
                            end else begin
                                ctrl.iMemAddrSelect = cpuControlPkg::F_PC_PLUS_ONE;
                            end
                        end
                        cpuControlPkg::C_HLT: begin
                            ctrl.iMemReadEnable = 1'b0;  // spin on the same word
                            ctrl.pcWriteEn      = 1'b0;
                        end
                        default: ;  // nop and undecoded words
                    endcase
                end
            end
            cpuControlPkg::S_JUMP: begin
                ctrl.iMemAddrSelect = cpuControlPkg::F_INSTR_WORD;
                ctrl.iMemReadEnable = 1'b1;
                ctrl.pcWriteEn      = 1'b1;
            end
            cpuControlPkg::S_CALL: begin
                ctrl                = pushWord(cpuControlPkg::D_PC1_MSB);
                ctrl.iMemAddrSelect = cpuControlPkg::F_INSTR_WORD;
                ctrl.iMemReadEnable = 1'b1;
                ctrl.pcWriteEn      = 1'b1;
            end
            cpuControlPkg::S_INTERRUPT: begin
                ctrl                 = pushWord(cpuControlPkg::D_ADDR_MSB);
                ctrl.statusSrcSelect = cpuControlPkg::STS_DISABLE_IRQ;
                ctrl.flagEnable      = 1'b1;
                ctrl.iMemAddrSelect  = cpuControlPkg::F_IRQ_VECTOR;
                ctrl.iMemReadEnable  = 1'b1;
                ctrl.pcWriteEn       = 1'b1;
                take                 = 1'b1;  // arbiter clears the winner
            end
            cpuControlPkg::S_START: begin
                ctrl.iMemReadEnable = startDone;
                ctrl.pcWriteEn      = startDone;  // first fetch commit
                nextState = startDone ? cpuControlPkg::S_PART1 : cpuControlPkg::S_START;
            end
            default: begin  // S_RESET
                nextState = resetReq ? cpuControlPkg::S_RESET : cpuControlPkg::S_PART1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: cpuControl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings_settings.svh"

module cpuControl (
    input  wire logic                          clk,
    input  wire logic                          arstN,
    input  wire logic [`CPU_INSTR_WIDTH-1:0]   instr,
    input  wire cpuControlPkg::flags_t         flags,
    input  wire logic [`CPU_IRQ_COUNT-1:0]     irq,
    input  wire logic                          cpuReset,
    output cpuControlPkg::ctrlWord_t           ctrl,
    output logic [`CPU_INSTR_WIDTH-1:0]        irqVector,
    output logic [`CPU_IRQ_COUNT-1:0]          irqClr,
    output logic                               resetOut
);

    cpuControlPkg::decoded_t dec;
    logic irqPending, take;        // arbiter handshake-free strobes
    logic resetReq, startDone, inStart;

    instrDecoder decoder0 (
        .instr (instr),
        .flags (flags),
        .dec   (dec)
    );

    interruptArbiter arbiter0 (
        .clk        (clk),
        .arstN      (arstN),
        .irq        (irq),
        .take       (take),
        .irqPending (irqPending),
        .irqVector  (irqVector),
        .irqClr     (irqClr)
    );

    startupSequencer startup0 (
        .clk       (clk),
        .arstN     (arstN),
        .cpuReset  (cpuReset),
        .inStart   (inStart),
        .resetReq  (resetReq),
        .startDone (startDone)
    );

    controlSequencer sequencer0 (
        .clk             (clk),
        .arstN           (arstN),
        .dec             (dec),
        .interruptEnable (flags.interruptEnable),
        .irqPending      (irqPending),
        .resetReq        (resetReq),
        .startDone       (startDone),
        .ctrl            (ctrl),
        .take            (take),
        .inStart         (inStart),
        .resetOut        (resetOut)
    );

endmodule

`default_nettype wire

// File: cpuControlPkg.sv
`default_nettype none

package cpuControlPkg;

    // ********************
    // sequencer states
    typedef enum logic [2:0] {
        S_PART1,      // first cycle of every instruction
        S_PART2,      // ret, first stack read done
        S_PART3,      // ret, load return address
        S_JUMP,       // target word on the fetch bus
        S_CALL,       // push msb, then jump
        S_INTERRUPT,  // push msb, go to isr
        S_START,      // power-up wait
        S_RESET       // parked by soft reset
    } state_t;

    typedef enum logic [3:0] {
        C_ALU_IMM,
        C_ALU_REG,    // includes mov and single register forms
        C_BRANCH,
        C_JUMP,
        C_CALL,
        C_RET,
        C_NOP,
        C_HLT,
        C_OTHER       // not decoded, just advances
    } instrClass_t;

    typedef enum logic [2:0] {
        COND_ALWAYS,
        COND_CARRY,
        COND_NOT_CARRY,
        COND_ZERO,
        COND_NOT_ZERO,
        COND_NEG,
        COND_NOT_NEG,
        COND_ALWAYS2
    } condCode_t;

    // ********************
    // mux select encodings
    typedef enum logic [2:0] {
        F_PC,           // sequential fetch
        F_PC_PLUS_ONE,  // skip the trailing address word
        F_IRQ_VECTOR,
        F_INSTR_WORD,   // address word just fetched
        F_BRANCH_REL,
        F_RET_ADDR,     // popped bytes
        F_BRANCH_ABS
    } fetchSel_t;

    typedef enum logic [2:0] {
        D_ALU_OUT,
        D_PC1_MSB,
        D_PC1_LSB,
        D_ADDR_MSB,     // current address, interrupt push
        D_ADDR_LSB
    } dataSel_t;

    typedef enum logic [1:0] {
        STS_ALU_FLAGS   = 2'b00,  // alu flags, keep ie
        STS_DISABLE_IRQ = 2'b11   // clear ie, keep the rest
    } statusSel_t;

    // ********************
    // bundles
    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic interruptEnable;
    } flags_t;

    typedef struct packed {
        instrClass_t instrClass;
        logic [3:0]  aluMode;
        logic        flagUpdate;       // low for ldi and mov
        logic [3:0]  regBSelect;
        logic        condMet;
        logic        branchAbs;        // instr[0] picks absolute target
        logic        uninterruptible;
    } decoded_t;

    typedef struct packed {
        logic       regFileWriteEnable;
        logic [3:0] regFileOutBSelect;
        logic       spDecrement;       // const source for stack push
        logic       aluSrcBImm;
        logic [3:0] aluMode;
        dataSel_t   dMemDataSelect;
        logic       dMemWriteEn;
        logic       dMemReadEn;
        statusSel_t statusSrcSelect;
        logic       flagEnable;
        fetchSel_t  iMemAddrSelect;
        logic       iMemReadEnable;
        logic       pcWriteEn;
    } ctrlWord_t;

endpackage

`default_nettype wire

// File: cpuSettings_settings.svh
`ifndef CPU_SETTINGS_SETTINGS_SVH
`define CPU_SETTINGS_SETTINGS_SVH

// ********************
// datapath widths
`define CPU_INSTR_WIDTH 16       // instruction word and fetch address
`define CPU_IRQ_COUNT 4          // interrupt request lines

// ********************
// timing and vectors
`define CPU_START_DELAY 40       // cycles in START before first fetch
`define CPU_IRQ_VECTOR_BASE 20   // isr address of line 0
`define CPU_IRQ_VECTOR_STEP 10   // spacing between isr entries
`define CPU_SP_LOW_REG 14        // low byte of stack pointer
`define CPU_RESET_SYNC_STAGES 2  // soft reset synchronizer depth

`endif

// File: instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings_settings.svh"

module instrDecoder (
    input  wire logic [`CPU_INSTR_WIDTH-1:0] instr,
    input  wire cpuControlPkg::flags_t       flags,
    output cpuControlPkg::decoded_t          dec
);

    logic isAluImm, isAluReg, isBranch, isJump, isCall, isRet, isNop, isHlt;

    // ********************
    // opcode patterns, low nibble first
    assign isAluImm = (instr[3:0] >= 4'd1) && (instr[3:0] <= 4'd7);
    assign isAluReg = (instr[3:0] == 4'b1010 && instr[7:4] >= 4'd1 && instr[7:4] <= 4'd9)
                   || (instr[3:0] == 4'b1111 && instr[7:4] >= 4'hA && instr[11:8] == 4'h0);
    assign isBranch = (instr[3:0] == 4'b1110)
                   || (instr[8:0] == 9'b0_0001_1111 && !instr[12]);  // jmpi form
    assign isJump   = (instr[12:0] == 13'h002F);
    assign isCall   = (instr[12:0] == 13'h003F);
    assign isRet    = (instr[12:0] == 13'h004F);
    assign isNop    = (instr == '0);
    assign isHlt    = (instr == '1);

    always_comb begin
        if (isHlt) begin
            dec.instrClass = cpuControlPkg::C_HLT;
        end else if (isNop) begin
            dec.instrClass = cpuControlPkg::C_NOP;
        end else if (isAluImm) begin
            dec.instrClass = cpuControlPkg::C_ALU_IMM;
        end else if (isAluReg) begin
            dec.instrClass = cpuControlPkg::C_ALU_REG;
        end else if (isBranch) begin
            dec.instrClass = cpuControlPkg::C_BRANCH;
        end else if (isJump) begin
            dec.instrClass = cpuControlPkg::C_JUMP;
        end else if (isCall) begin
            dec.instrClass = cpuControlPkg::C_CALL;
        end else if (isRet) begin
            dec.instrClass = cpuControlPkg::C_RET;
        end else begin
            dec.instrClass = cpuControlPkg::C_OTHER;  // dropped opcodes
        end

        dec.aluMode    = isAluImm ? {1'b0, instr[2:0]} : instr[6:3];
        dec.flagUpdate = isAluImm ? (instr[3:1] != 3'b001)    // ldi
                                  : (instr[6:3] != 4'b0001);  // mov
        dec.regBSelect = instr[11:8];
        dec.branchAbs  = instr[0];

        // hlt, or csr clearing the global enable
        dec.uninterruptible = isHlt || (instr[7:0] == 8'hE8 && !instr[11]);

        case (cpuControlPkg::condCode_t'(instr[15:13]))
            cpuControlPkg::COND_CARRY:     dec.condMet = flags.carry;
            cpuControlPkg::COND_NOT_CARRY: dec.condMet = !flags.carry;
            cpuControlPkg::COND_ZERO:      dec.condMet = flags.zero;
            cpuControlPkg::COND_NOT_ZERO:  dec.condMet = !flags.zero;
            cpuControlPkg::COND_NEG:       dec.condMet = flags.negative;
            cpuControlPkg::COND_NOT_NEG:   dec.condMet = !flags.negative;
            default:                       dec.condMet = 1'b1;  // both always codes
        endcase
    end

endmodule

`default_nettype wire

// File: interruptArbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings_settings.svh"

module interruptArbiter (
    input  wire logic                          clk,
    input  wire logic                          arstN,
    input  wire logic [`CPU_IRQ_COUNT-1:0]     irq,
    input  wire logic                          take,
    output logic                               irqPending,
    output logic [`CPU_INSTR_WIDTH-1:0]        irqVector,
    output logic [`CPU_IRQ_COUNT-1:0]          irqClr
);

    localparam int IdxW = $clog2(`CPU_IRQ_COUNT);
    localparam int VecW = `CPU_INSTR_WIDTH;

    logic [IdxW-1:0]            winIdx;
    logic [`CPU_IRQ_COUNT-1:0]  winOneHot;

    assign irqPending = |irq;
    assign winOneHot  = irq & (~irq + 1'b1);  // isolate lowest set line

    always_comb begin
        winIdx = '0;
        for (int i = `CPU_IRQ_COUNT - 1; i >= 0; i--) begin
            if (irq[i]) winIdx = i[IdxW-1:0];  // last hit is the lowest line
        end
    end

    assign irqVector = irqPending
        ? VecW'(`CPU_IRQ_VECTOR_BASE + winIdx * `CPU_IRQ_VECTOR_STEP) : '0;

    // one-cycle clear, latched from the take cycle winner
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            irqClr <= '0;
        end else begin
            irqClr <= take ? winOneHot : '0;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
cpuControlPkg.sv
instrDecoder.sv
interruptArbiter.sv
startupSequencer.sv
controlSequencer.sv
cpuControl.sv
tbCpuControl.sv

// File: startupSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings_settings.svh"

module startupSequencer (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic cpuReset,
    input  wire logic inStart,
    output logic      resetReq,
    output logic      startDone
);

    localparam int CntW = $clog2(`CPU_START_DELAY + 1);

    logic [`CPU_RESET_SYNC_STAGES-1:0] syncReg;
    logic [CntW-1:0]                   delayCnt;

    // ********************
    // soft reset synchronizer, comes up asserted
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncReg <= '1;
        end else begin
            syncReg <= {syncReg[`CPU_RESET_SYNC_STAGES-2:0], cpuReset};
        end
    end

    assign resetReq = syncReg[`CPU_RESET_SYNC_STAGES-1];

    // ********************
    // power-up delay
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            delayCnt <= '0;
        end else if (inStart) begin
            delayCnt <= delayCnt + 1'b1;
        end else begin
            delayCnt <= '0;  // idle outside START
        end
    end

    assign startDone = (delayCnt == CntW'(`CPU_START_DELAY));

endmodule

`default_nettype wire

// File: tbCpuControl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuSettings_settings.svh"

module tbCpuControl;

    localparam int HalfPeriod   = 20;
    localparam int SettleDelay  = 10;  // sample point after the falling edge
    localparam int ResetCycles  = 16;
    localparam int IrqCount     = `CPU_IRQ_COUNT;
    localparam int AluRounds    = 16;  // one imm and one reg word each
    localparam int BranchRounds = 4;   // all eight codes each
    localparam int IrqRounds    = 8;
    localparam int SeqCycles    = ResetCycles + `CPU_RESET_SYNC_STAGES + `CPU_START_DELAY + 2
                                + 2 * AluRounds + 8 * BranchRounds + 16 + 4 * IrqRounds + 3 + 16;
    localparam int TimeoutCycles = 2 * SeqCycles;
    localparam logic [15:0] NopWord = 16'h0000;
    localparam logic [15:0] HltWord = 16'hFFFF;

    logic                          clk, arstN, cpuReset, resetOut;
    logic [`CPU_INSTR_WIDTH-1:0]   instr, irqVector;
    logic [IrqCount-1:0]           irq, irqClr;
    cpuControlPkg::flags_t         flags;
    cpuControlPkg::ctrlWord_t      ctrl;
    integer                        seed;
    int                            cycleCount = 0;

    cpuControl dut0 (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .flags     (flags),
        .irq       (irq),
        .cpuReset  (cpuReset),
        .ctrl      (ctrl),
        .irqVector (irqVector),
        .irqClr    (irqClr),
        .resetOut  (resetOut)
    );

    always #HalfPeriod clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic abortRun(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    // all inputs move together on the falling edge
    task automatic step(input logic [15:0] word, input cpuControlPkg::flags_t f,
                        input logic [IrqCount-1:0] lines, input logic rst);
        @(negedge clk);
        instr    = word;
        flags    = f;
        irq      = lines;
        cpuReset = rst;
        #SettleDelay;  // combinational word has settled
    endtask

    function automatic logic anyWrite(input cpuControlPkg::ctrlWord_t w);
        return w.regFileWriteEnable | w.dMemWriteEn | w.flagEnable | w.spDecrement;
    endfunction

    // ********************
    // reference rules
    function automatic logic condHolds(input int code, input cpuControlPkg::flags_t f);
        case (code)
            1: return f.carry;
            2: return !f.carry;
            3: return f.zero;
            4: return !f.zero;
            5: return f.negative;
            6: return !f.negative;
            default: return 1'b1;  // codes 0 and 7 always hold
        endcase
    endfunction

    function automatic logic isLdi(input logic [3:0] opcode);
        return opcode == 4'h2 || opcode == 4'h3;  // load immediate opcodes
    endfunction

    function automatic int lowestLine(input logic [IrqCount-1:0] lines);
        for (int i = 0; i < IrqCount; i++) begin
            if (lines[i]) return i;  // line 0 wins
        end
        return -1;
    endfunction

    // taken form of a flow word must not occur here, one cycle then HLT parks
    task automatic untakenFlow(input logic [15:0] word);
        step(word, '0, '0, 1'b0);
        assert (ctrl.pcWriteEn && ctrl.iMemAddrSelect == cpuControlPkg::F_PC_PLUS_ONE
                && !ctrl.dMemWriteEn && !ctrl.dMemReadEn)
            else abortRun($sformatf("untaken word %h did not skip to PC_PLUS_ONE", word));
        step(HltWord, '0, '0, 1'b0);
        assert (!ctrl.pcWriteEn) else abortRun($sformatf("untaken word %h ran long", word));
    endtask

    // ********************
    // concurrent checks
    resetQuiet: assert property (@(posedge clk) !arstN |-> !anyWrite(ctrl) && !ctrl.pcWriteEn
                                 && irqClr == '0 && !resetOut)
        else abortRun("enable, irqClr or resetOut active while arstN is low");
    parkedQuiet: assert property (@(posedge clk) disable iff (!arstN)
                                  resetOut |-> !anyWrite(ctrl) && !ctrl.pcWriteEn)
        else abortRun("enable active while parked in RESET");
    singleClear: assert property (@(posedge clk) $onehot0(irqClr))
        else abortRun($sformatf("irqClr %b names more than one line", irqClr));

    initial begin
        cpuControlPkg::flags_t     f;
        cpuControlPkg::fetchSel_t  expSel;
        logic [31:0]               rnd;
        logic [15:0]               word;
        logic [IrqCount-1:0]       pattern, expectClr;
        int                        idx, count;

        seed     = 27654;
        clk      = 1'b0;
        arstN    = 1'b0;
        cpuReset = 1'b0;
        instr    = HltWord;  // parks PART1 right after the first fetch
        flags    = '0;
        irq      = '0;
        repeat (ResetCycles) @(negedge clk);

        // ********************
        // power-up delay
        arstN = 1'b1;
        #SettleDelay;
        count = 0;
        while (!ctrl.pcWriteEn) begin
            assert (!anyWrite(ctrl)) else abortRun("write enable active during start");
            count++;
            step(HltWord, '0, '0, 1'b0);
        end
        assert (count == `CPU_RESET_SYNC_STAGES + `CPU_START_DELAY && !anyWrite(ctrl))
            else abortRun($sformatf("first fetch after %0d cycles, expected %0d", count,
                                    `CPU_RESET_SYNC_STAGES + `CPU_START_DELAY));
        step(HltWord, '0, '0, 1'b0);
        assert (!ctrl.pcWriteEn) else abortRun("pcWriteEn high for more than one start cycle");

        // ********************
        // alu words
        for (int i = 0; i < AluRounds; i++) begin
            word      = 16'($random(seed));
            word[3:0] = 4'(1 + i % 7);  // all seven immediate opcodes
            step(word, '0, '0, 1'b0);
            assert (ctrl.aluMode == {1'b0, word[2:0]} && ctrl.aluSrcBImm
                    && ctrl.regFileWriteEnable && ctrl.pcWriteEn
                    && ctrl.flagEnable == !isLdi(word[3:0]))  // ldi keeps flags
                else abortRun($sformatf("ALU_IMM %h gave mode %h flagEnable %b", word,
                                        ctrl.aluMode, ctrl.flagEnable));
            word      = 16'($random(seed));
            word[7:0] = {4'(1 + i % 9), 4'hA};
            step(word, '0, '0, 1'b0);
            assert (ctrl.regFileOutBSelect == word[11:8] && !ctrl.aluSrcBImm
                    && ctrl.regFileWriteEnable && ctrl.pcWriteEn
                    && ctrl.flagEnable == (word[7:4] != 4'h8))  // mov keeps flags
                else abortRun($sformatf("ALU_REG %h gave bSel %h flagEnable %b", word,
                                        ctrl.regFileOutBSelect, ctrl.flagEnable));
        end

        // ********************
        // conditional branches
        for (int r = 0; r < BranchRounds; r++) begin
            for (int c = 0; c < 8; c++) begin
                rnd = $random(seed);
                f   = {rnd[2:0], 1'b0};  // random carry, zero, negative
                if ((r + c) % 2 == 1) begin
                    word   = {3'(c), 1'b0, rnd[5:3], 9'h01F};  // absolute form
                    expSel = cpuControlPkg::F_BRANCH_ABS;
                end else begin
                    word   = {3'(c), rnd[16:8], 4'hE};
                    expSel = cpuControlPkg::F_BRANCH_REL;
                end
                if (!condHolds(c, f)) expSel = cpuControlPkg::F_PC;
                step(word, f, '0, 1'b0);
                assert (ctrl.iMemAddrSelect == expSel && ctrl.pcWriteEn)
                    else abortRun($sformatf("branch %h flags %b selected %0d, expected %0d",
                                            word, f, ctrl.iMemAddrSelect, expSel));
            end
        end

        // ********************
        // jump, call, return
        step({3'd0, 13'h002F}, '0, '0, 1'b0);
        assert (!ctrl.dMemWriteEn && !ctrl.spDecrement) else abortRun("JUMP wrote memory");
        step(HltWord, '0, '0, 1'b0);  // target word cycle ignores instr
        assert (ctrl.iMemAddrSelect == cpuControlPkg::F_INSTR_WORD && ctrl.pcWriteEn)
            else abortRun("JUMP second cycle did not load INSTR_WORD");
        step(HltWord, '0, '0, 1'b0);
        assert (!ctrl.pcWriteEn) else abortRun("JUMP lasted more than two cycles");
        step({3'd7, 13'h003F}, '0, '0, 1'b0);
        assert (ctrl.dMemWriteEn && ctrl.dMemDataSelect == cpuControlPkg::D_PC1_LSB
                && ctrl.spDecrement && ctrl.regFileOutBSelect == 4'(`CPU_SP_LOW_REG))
            else abortRun("CALL first cycle did not push PC1_LSB");
        step(HltWord, '0, '0, 1'b0);
        assert (ctrl.dMemWriteEn && ctrl.dMemDataSelect == cpuControlPkg::D_PC1_MSB
                && ctrl.spDecrement && ctrl.pcWriteEn
                && ctrl.iMemAddrSelect == cpuControlPkg::F_INSTR_WORD)
            else abortRun("CALL second cycle did not push PC1_MSB and jump");
        step(HltWord, '0, '0, 1'b0);
        assert (!ctrl.pcWriteEn && !ctrl.dMemWriteEn) else abortRun("CALL ran long");
        f = 4'b0100;  // zero set
        for (int k = 0; k < 3; k++) begin
            step({3'd3, 13'h004F}, f, '0, 1'b0);  // RET held as in the instruction reg
            assert (k < 2 ? (ctrl.dMemReadEn && !ctrl.pcWriteEn)
                          : (ctrl.pcWriteEn && !ctrl.dMemReadEn
                             && ctrl.iMemAddrSelect == cpuControlPkg::F_RET_ADDR))
                else abortRun($sformatf("RET cycle %0d has wrong read or fetch control", k));
        end
        step(HltWord, '0, '0, 1'b0);
        assert (!ctrl.pcWriteEn) else abortRun("RET lasted more than three cycles");
        untakenFlow({3'd1, 13'h002F});  // carry clear
        untakenFlow({3'd3, 13'h003F});  // zero clear
        untakenFlow({3'd5, 13'h004F});  // negative clear

        // ********************
        // interrupt entry
        for (int r = 0; r < IrqRounds; r++) begin
            rnd     = $random(seed);
            pattern = rnd[IrqCount-1:0];
            if (pattern == '0) pattern[IrqCount-1] = 1'b1;
            idx       = lowestLine(pattern);
            expectClr = '0;
            expectClr[idx] = 1'b1;
            for (int k = 0; k < 2; k++) begin
                step(NopWord, 4'b0001, pattern, 1'b0);
                assert (ctrl.dMemWriteEn && ctrl.flagEnable && irqClr == '0
                        && ctrl.statusSrcSelect == cpuControlPkg::STS_DISABLE_IRQ
                        && ctrl.dMemDataSelect == (k == 0 ? cpuControlPkg::D_ADDR_LSB
                                                          : cpuControlPkg::D_ADDR_MSB)
                        && ctrl.pcWriteEn == (k == 1)
                        && int'(irqVector) == `CPU_IRQ_VECTOR_BASE + idx * `CPU_IRQ_VECTOR_STEP)
                    else abortRun($sformatf("irq %b entry cycle %0d, vector %0d", pattern, k,
                                            irqVector));
            end
            assert (ctrl.iMemAddrSelect == cpuControlPkg::F_IRQ_VECTOR)
                else abortRun("interrupt cycle did not select IRQ_VECTOR");
            step(NopWord, '0, '0, 1'b0);  // clear must survive irq dropping
            assert (irqClr == expectClr && ctrl.pcWriteEn)
                else abortRun($sformatf("irqClr %b, expected %b", irqClr, expectClr));
            step(NopWord, '0, '0, 1'b0);
            assert (irqClr == '0) else abortRun("irqClr lasted more than one cycle");
        end
        step(NopWord, '0, 4'b0110, 1'b0);  // enable clear
        assert (ctrl.pcWriteEn && !ctrl.dMemWriteEn && !ctrl.flagEnable)
            else abortRun("interrupt taken with interruptEnable clear");
        step(HltWord, 4'b0001, 4'b0110, 1'b0);
        assert (!ctrl.pcWriteEn && !ctrl.dMemWriteEn) else abortRun("interrupt taken on HLT");
        step(NopWord, '0, '0, 1'b0);
        assert (irqClr == '0) else abortRun("irqClr pulsed without an interrupt entry");

        // ********************
        // soft reset
        step(NopWord, '0, '0, 1'b1);
        count = 0;
        while (!resetOut) begin
            assert (count < 3) else abortRun("resetOut did not rise within three cycles");
            step(NopWord, '0, '0, 1'b1);
            count++;
        end
        repeat (4) begin
            step(NopWord, '0, '0, 1'b1);
            assert (resetOut) else abortRun("resetOut fell while cpuReset was held");
        end
        step(NopWord, '0, '0, 1'b0);
        count = 0;
        while (!ctrl.pcWriteEn) begin
            assert (count < 4) else abortRun("unit stayed in RESET after cpuReset fell");
            step(NopWord, '0, '0, 1'b0);
            count++;
        end
        assert (!resetOut && ctrl.iMemAddrSelect == cpuControlPkg::F_PC)
            else abortRun("first NOP after soft reset has wrong fetch control");
        step(NopWord, '0, '0, 1'b0);
        assert (ctrl.pcWriteEn) else abortRun("NOP after soft reset did not advance");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
